/* common/tsc_isa_pkg.sv */
package tsc_isa_pkg;

    localparam int word_width = 16;
    localparam int reg_count = 4;

    typedef logic [word_width-1:0] word_t;

    typedef enum logic [3:0] {
        BNE_OP = 4'd0,
        BEQ_OP = 4'd1,
        BGZ_OP = 4'd2,
        BLZ_OP = 4'd3,
        ADI_OP = 4'd4,
        ORI_OP = 4'd5,
        LHI_OP = 4'd6,
        LWD_OP = 4'd7,
        SWD_OP = 4'd8,
        JMP_OP = 4'd9,
        JAL_OP = 4'd10,
        ALU_OP = 4'd15
    } opcode_t;

    // Register jumps, WWD and HLT live under the R-type opcode
    localparam opcode_t JPR_OP = ALU_OP;
    localparam opcode_t JRL_OP = ALU_OP;
    localparam opcode_t WWD_OP = ALU_OP;
    localparam opcode_t HLT_OP = ALU_OP;

    typedef enum logic [5:0] {
        FUNC_ADD = 6'd0,
        FUNC_SUB = 6'd1,
        FUNC_AND = 6'd2,
        FUNC_ORR = 6'd3,
        FUNC_NOT = 6'd4,
        FUNC_TCP = 6'd5,
        FUNC_SHL = 6'd6,
        FUNC_SHR = 6'd7,
        FUNC_JPR = 6'd25,
        FUNC_JRL = 6'd26,
        FUNC_WWD = 6'd28,
        FUNC_HLT = 6'd29
    } func_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        func_t      func;
    } r_fields_t;

    // Immediate is sign-extended except for ORI and LHI
    typedef struct packed {
        opcode_t    opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } i_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [11:0] target;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_u;

endpackage

/* common/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    typedef enum logic [3:0] {
        IF_1,
        IF_2,
        ID,
        EX_1,
        EX_2,
        MEM_1,
        MEM_2,
        WB,
        HALTED
    } state_t;

    typedef enum logic [1:0] {ADD_MODE, SUB_MODE, FUNC_MODE} alu_sel_t;
    typedef enum logic {PC_A, REG_A} src_a_t;
    typedef enum logic [1:0] {REG_B, ONE_B, IMM_B} src_b_t;
    typedef enum logic {ALU_PC, ALUOUT_PC} pc_src_t;

    // LINK_W writes register 2
    typedef enum logic [1:0] {RD_W, RT_W, LINK_W} dest_t;

    typedef struct packed {
        logic     ir_write;
        logic     mem_read;
        logic     mem_write;
        logic     i_or_d;
        logic     mem_to_reg;
        logic     reg_write;
        dest_t    reg_dest;
        logic     pc_to_reg;
        logic     pc_write;
        logic     pc_write_cond;
        pc_src_t  pc_src;
        src_a_t   src_a;
        src_b_t   src_b;
        alu_sel_t alu_sel;
        logic     wwd;
        logic     inst_done;
    } ctrl_t;

endpackage

/* datapath/alu.sv */
`timescale 1ns/1ns

module alu (
    input  tsc_isa_pkg::word_t     a,
    input  tsc_isa_pkg::word_t     b,
    input  cpu_ctrl_pkg::alu_sel_t alu_sel,
    input  tsc_isa_pkg::opcode_t   opcode,
    input  tsc_isa_pkg::func_t     func,
    output tsc_isa_pkg::word_t     result
);
    import tsc_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    always_comb begin
        case (alu_sel)
            ADD_MODE: result = a + b;
            SUB_MODE: result = a - b;
            default: begin
                case (opcode)
                    ALU_OP: begin
                        case (func)
                            FUNC_ADD: result = a + b;
                            FUNC_SUB: result = a - b;
                            FUNC_AND: result = a & b;
                            FUNC_ORR: result = a | b;
                            FUNC_NOT: result = ~a;
                            FUNC_TCP: result = ~a + word_t'(1);
                            FUNC_SHL: result = {a[word_width-2:0], 1'b0};
                            FUNC_SHR: result = {a[word_width-1], a[word_width-1:1]};
                            // Register jumps pass A through
                            default:  result = a;
                        endcase
                    end
                    ORI_OP:         result = a | b;
                    LHI_OP:         result = {b[7:0], 8'h00};
                    // Jump target keeps the top PC bits
                    JMP_OP, JAL_OP: result = {a[word_width-1:12], b[11:0]};
                    // ADI and load/store address add
                    default:        result = a + b;
                endcase
            end
        endcase
    end

endmodule

/* datapath/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [1:0]         read_1,
    input  logic [1:0]         read_2,
    input  logic [1:0]         write_sel,
    input  logic               write_en,
    input  tsc_isa_pkg::word_t write_data,
    output tsc_isa_pkg::word_t data_1,
    output tsc_isa_pkg::word_t data_2
);
    import tsc_isa_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_sel] <= write_data;
        end
    end

    // Asynchronous read ports
    assign data_1 = regs[read_1];
    assign data_2 = regs[read_2];

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ns

module datapath (
    input  logic                clk,
    input  logic                reset_n,
    input  cpu_ctrl_pkg::ctrl_t ctrl,
    input  tsc_isa_pkg::word_t  read_data,
    output tsc_isa_pkg::word_t  address,
    output tsc_isa_pkg::word_t  write_data,
    output tsc_isa_pkg::instr_u ir,
    output logic                branch_cond,
    output tsc_isa_pkg::word_t  output_port
);
    import tsc_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t      pc;
    word_t      alu_out;
    word_t      mdr;
    word_t      a_reg;
    word_t      b_reg;
    instr_u     ir_q;
    logic       fetch_q;
    word_t      rf_data_1;
    word_t      rf_data_2;
    word_t      imm_ext;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    word_t      reg_wdata;
    word_t      pc_next;
    logic [1:0] write_sel;
    logic       pc_en;

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    // Set in the second fetch cycle so the sequencer sees the fresh word
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= '0;
            fetch_q <= 1'b0;
        end else begin
            fetch_q <= ctrl.mem_read && !ctrl.i_or_d && !ctrl.ir_write;
            if (pc_en) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        a_reg <= rf_data_1;
        b_reg <= rf_data_2;
        if (ctrl.ir_write) begin
            ir_q <= instr_u'(read_data);
        end
        // ALUOut holds the data address during memory states
        if (!ctrl.i_or_d) begin
            alu_out <= alu_result;
        end
        if (ctrl.mem_read && ctrl.i_or_d) begin
            mdr <= read_data;
        end
    end

    assign ir = fetch_q ? instr_u'(read_data) : ir_q;

    //////////////////////////////////////////////////////////////////////
    // Operand and writeback selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ir.i.opcode)
            ORI_OP, LHI_OP: imm_ext = {8'h00, ir.i.imm};
            JMP_OP, JAL_OP: imm_ext = {4'h0, ir.j.target};
            default:        imm_ext = {{8{ir.i.imm[7]}}, ir.i.imm};
        endcase
    end

    assign alu_a = (ctrl.src_a == REG_A) ? a_reg : pc;

    always_comb begin
        case (ctrl.src_b)
            REG_B:   alu_b = b_reg;
            IMM_B:   alu_b = imm_ext;
            default: alu_b = word_t'(1);
        endcase
    end

    always_comb begin
        case (ctrl.reg_dest)
            RT_W:    write_sel = ir.i.rt;
            LINK_W:  write_sel = 2'd2;
            default: write_sel = ir.r.rd;
        endcase
    end

    // Link value is PC, which has already stepped to PC + 1
    assign reg_wdata = ctrl.pc_to_reg ? pc : (ctrl.mem_to_reg ? mdr : alu_out);

    assign pc_next = (ctrl.pc_src == ALUOUT_PC) ? alu_out : alu_result;
    assign pc_en = ctrl.pc_write || (ctrl.pc_write_cond && branch_cond);

    always_comb begin
        case (ir.i.opcode)
            BNE_OP:  branch_cond = (a_reg != b_reg);
            BEQ_OP:  branch_cond = (a_reg == b_reg);
            BGZ_OP:  branch_cond = !a_reg[word_width-1] && (a_reg != '0);
            BLZ_OP:  branch_cond = a_reg[word_width-1];
            default: branch_cond = 1'b0;
        endcase
    end

    assign address = ctrl.i_or_d ? alu_out : pc;
    assign write_data = b_reg;
    assign output_port = a_reg;

    register_file u_register_file (
        .clk        (clk),
        .reset_n    (reset_n),
        .read_1     (ir.r.rs),
        .read_2     (ir.r.rt),
        .write_sel  (write_sel),
        .write_en   (ctrl.reg_write),
        .write_data (reg_wdata),
        .data_1     (rf_data_1),
        .data_2     (rf_data_2)
    );

    alu u_alu (
        .a       (alu_a),
        .b       (alu_b),
        .alu_sel (ctrl.alu_sel),
        .opcode  (ir.r.opcode),
        .func    (ir.r.func),
        .result  (alu_result)
    );

endmodule

/* control/control_unit.sv */
`timescale 1ns/1ns

module control_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  tsc_isa_pkg::instr_u ir,
    input  logic                branch_cond,
    output cpu_ctrl_pkg::ctrl_t ctrl
);
    import tsc_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    state_t  state;
    state_t  next_state;
    opcode_t op;
    func_t   fn;
    logic    is_rtype;
    logic    is_itype;
    logic    is_load;
    logic    is_store;
    logic    is_jrel;
    logic    is_jreg;
    logic    is_link;
    logic    is_branch;
    logic    is_lhi;
    logic    is_wwd;
    logic    is_hlt;

    //////////////////////////////////////////////////////////////////////
    // Instruction classes
    //////////////////////////////////////////////////////////////////////

    assign op = ir.r.opcode;
    assign fn = ir.r.func;

    assign is_rtype  = (op == ALU_OP) && (fn inside {FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR,
                                                     FUNC_NOT, FUNC_TCP, FUNC_SHL, FUNC_SHR});
    assign is_itype  = (op == ADI_OP) || (op == ORI_OP);
    assign is_load   = (op == LWD_OP);
    assign is_store  = (op == SWD_OP);
    assign is_jrel   = (op == JMP_OP) || (op == JAL_OP);
    assign is_jreg   = ((op == JPR_OP) && (fn == FUNC_JPR)) || ((op == JRL_OP) && (fn == FUNC_JRL));
    assign is_link   = (op == JAL_OP) || ((op == JRL_OP) && (fn == FUNC_JRL));
    assign is_branch = op inside {BNE_OP, BEQ_OP, BGZ_OP, BLZ_OP};
    assign is_lhi    = (op == LHI_OP);
    assign is_wwd    = (op == WWD_OP) && (fn == FUNC_WWD);
    assign is_hlt    = (op == HLT_OP) && (fn == FUNC_HLT);

    //////////////////////////////////////////////////////////////////////
    // Control word per state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = '0;
        // ALU idles on PC + 1 unless a state needs it
        ctrl.src_a = PC_A;
        ctrl.src_b = ONE_B;
        ctrl.alu_sel = ADD_MODE;
        ctrl.pc_src = ALU_PC;
        ctrl.reg_dest = RD_W;
        case (state)
            IF_1: begin
                ctrl.mem_read = 1'b1;
            end
            IF_2: begin
                ctrl.mem_read = 1'b1;
                ctrl.ir_write = 1'b1;
                ctrl.inst_done = is_hlt;
            end
            EX_1: begin
                ctrl.alu_sel = FUNC_MODE;
                if (is_rtype) begin
                    ctrl.src_a = REG_A;
                    ctrl.src_b = REG_B;
                end else if (is_itype || is_load || is_store || is_lhi) begin
                    ctrl.src_a = REG_A;
                    ctrl.src_b = IMM_B;
                end else if (is_jrel || is_jreg) begin
                    // PC steps to PC + 1 while the target goes to ALUOut
                    ctrl.src_a = is_jrel ? PC_A : REG_A;
                    ctrl.src_b = IMM_B;
                    ctrl.pc_write = 1'b1;
                    ctrl.pc_src = ALUOUT_PC;
                end else if (is_branch) begin
                    ctrl.src_a = REG_A;
                    ctrl.src_b = REG_B;
                    ctrl.alu_sel = SUB_MODE;
                    ctrl.pc_write = 1'b1;
                    ctrl.pc_src = ALUOUT_PC;
                    ctrl.inst_done = !branch_cond;
                end else begin
                    // WWD and unknown words retire here
                    ctrl.wwd = is_wwd;
                    ctrl.pc_write = 1'b1;
                    ctrl.pc_src = ALUOUT_PC;
                    ctrl.inst_done = 1'b1;
                end
            end
            EX_2: begin
                ctrl.inst_done = 1'b1;
                if (is_branch) begin
                    // PC already holds PC + 1 for a taken branch
                    ctrl.src_b = IMM_B;
                    ctrl.pc_write_cond = 1'b1;
                end else begin
                    ctrl.pc_write = 1'b1;
                    ctrl.pc_src = ALUOUT_PC;
                    if (is_link) begin
                        ctrl.reg_write = 1'b1;
                        ctrl.reg_dest = LINK_W;
                        ctrl.pc_to_reg = 1'b1;
                    end
                end
            end
            MEM_1, MEM_2: begin
                ctrl.i_or_d = 1'b1;
                ctrl.mem_read = is_load;
                ctrl.mem_write = is_store;
                if (state == MEM_2 && is_store) begin
                    ctrl.pc_write = 1'b1;
                    ctrl.inst_done = 1'b1;
                end
            end
            WB: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dest = is_rtype ? RD_W : RT_W;
                ctrl.mem_to_reg = is_load;
                ctrl.pc_write = 1'b1;
                ctrl.inst_done = 1'b1;
            end
            default: begin
                // ID and HALTED keep the defaults
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State sequence
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = IF_1;
        case (state)
            IF_1: next_state = IF_2;
            IF_2: begin
                if (is_hlt) begin
                    next_state = HALTED;
                end else if (is_jrel || is_lhi) begin
                    next_state = EX_1;
                end else begin
                    next_state = ID;
                end
            end
            ID: next_state = EX_1;
            EX_1: begin
                if (is_load || is_store) begin
                    next_state = MEM_1;
                end else if (is_rtype || is_itype || is_lhi) begin
                    next_state = WB;
                end else if (is_jrel || is_jreg || (is_branch && branch_cond)) begin
                    next_state = EX_2;
                end
            end
            MEM_1: next_state = MEM_2;
            MEM_2: next_state = is_load ? WB : IF_1;
            HALTED: next_state = HALTED;
            default: next_state = IF_1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= IF_1;
        end else begin
            state <= next_state;
        end
    end

endmodule

/* hdl/cpu.sv */
`timescale 1ns/1ns

module cpu (
    input  logic               clk,
    input  logic               reset_n,
    output logic               mem_read,
    output logic               mem_write,
    output tsc_isa_pkg::word_t address,
    output tsc_isa_pkg::word_t write_data,
    input  tsc_isa_pkg::word_t read_data,
    output tsc_isa_pkg::word_t output_port,
    output logic               output_valid,
    output tsc_isa_pkg::word_t num_inst,
    output logic               halted
);
    import tsc_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    ctrl_t  ctrl;
    instr_u ir;
    logic   branch_cond;
    logic   halt_done;

    assign mem_read = ctrl.mem_read;
    assign mem_write = ctrl.mem_write;
    assign output_valid = ctrl.wwd;

    // HLT retires in IF_2 as the sequencer enters HALTED on the same edge
    assign halt_done = ctrl.inst_done && (ir.r.opcode == HLT_OP) && (ir.r.func == FUNC_HLT);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            num_inst <= '0;
            halted <= 1'b0;
        end else begin
            if (ctrl.inst_done) begin
                num_inst <= num_inst + word_t'(1);
            end
            if (halt_done) begin
                halted <= 1'b1;
            end
        end
    end

    control_unit u_control_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .ir          (ir),
        .branch_cond (branch_cond),
        .ctrl        (ctrl)
    );

    datapath u_datapath (
        .clk         (clk),
        .reset_n     (reset_n),
        .ctrl        (ctrl),
        .read_data   (read_data),
        .address     (address),
        .write_data  (write_data),
        .ir          (ir),
        .branch_cond (branch_cond),
        .output_port (output_port)
    );

endmodule

/* verif/cpu_assertions.sv */
`timescale 1ns/1ns

module cpu_assertions (
    input logic clk,
    input logic reset_n,
    input logic mem_read,
    input logic mem_write,
    input logic output_valid,
    input logic halted
);

    //////////////////////////////////////////////////////////////////////
    // Memory port and status rules
    //////////////////////////////////////////////////////////////////////

    // The single memory port moves one direction at a time
    mem_dir_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write were high in the same cycle");

    // WWD gives a single-cycle pulse
    valid_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        output_valid |=> !output_valid)
        else $error("output_valid stayed high for two cycles");

    halt_no_store: assert property (@(posedge clk) disable iff (!reset_n)
        halted |-> !mem_write)
        else $error("mem_write went high while halted");

endmodule

/* verif/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;
    import tsc_isa_pkg::*;

    localparam int mem_words = 256;
    localparam int data_base = 192;
    localparam int wait_limit = 200;
    localparam int quiet_cycles = 20;

    logic        clk;
    logic        reset_n;
    logic        mem_read;
    logic        mem_write;
    word_t       address;
    word_t       write_data;
    word_t       read_data;
    word_t       output_port;
    logic        output_valid;
    word_t       num_inst;
    logic        halted;

    word_t       mem [mem_words];
    word_t       prog_word [$];
    word_t       exp_out [$];
    word_t       ref_reg [reg_count];
    int          exec_count;
    int          store_addr;
    word_t       store_data;
    logic [31:0] lcg_state;

    cpu UUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .address      (address),
        .write_data   (write_data),
        .read_data    (read_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .halted       (halted)
    );

    bind cpu cpu_assertions u_cpu_assertions (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .output_valid (output_valid),
        .halted       (halted)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    // Read data shows up from the second cycle of a read strobe
    always @(negedge clk) begin
        if (mem_read) begin
            read_data <= mem[address[7:0]];
        end
    end

    always @(posedge clk) begin
        if (mem_write) begin
            mem[address[7:0]] = write_data;
        end
    end

    function automatic word_t fill_word(input int a);
        logic [7:0] low;
        low = a[7:0];
        return {low ^ 8'ha5, ~low};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Program building and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic word_t r_word(input func_t f, input logic [1:0] rs,
                                     input logic [1:0] rt, input logic [1:0] rd);
        instr_u w;
        w.r.opcode = ALU_OP;
        w.r.rs = rs;
        w.r.rt = rt;
        w.r.rd = rd;
        w.r.func = f;
        return word_t'(w);
    endfunction

    function automatic word_t i_word(input opcode_t op, input logic [1:0] rs,
                                     input logic [1:0] rt, input logic [7:0] imm);
        instr_u w;
        w.i.opcode = op;
        w.i.rs = rs;
        w.i.rt = rt;
        w.i.imm = imm;
        return word_t'(w);
    endfunction

    function automatic word_t j_word(input opcode_t op, input logic [11:0] target);
        instr_u w;
        w.j.opcode = op;
        w.j.target = target;
        return word_t'(w);
    endfunction

    // Results of the R-type functions as the ISA defines them
    function automatic word_t rtype_rule(input func_t f, input word_t a, input word_t b);
        case (f)
            FUNC_ADD: return a + b;
            FUNC_SUB: return a - b;
            FUNC_AND: return a & b;
            FUNC_ORR: return a | b;
            FUNC_NOT: return ~a;
            FUNC_TCP: return 16'd0 - a;
            FUNC_SHL: return a << 1;
            FUNC_SHR: return word_t'($signed(a) >>> 1);
            default:  return a;
        endcase
    endfunction

    task automatic emit(input word_t w, input bit runs);
        prog_word.push_back(w);
        if (runs) begin
            exec_count++;
        end
    endtask

    task automatic load_reg(input logic [1:0] r, input word_t value);
        emit(i_word(LHI_OP, 2'd0, r, value[15:8]), 1'b1);
        emit(i_word(ORI_OP, r, r, value[7:0]), 1'b1);
        ref_reg[r] = value;
    endtask

    task automatic show_reg(input logic [1:0] r, input bit runs);
        emit(r_word(FUNC_WWD, r, 2'd0, 2'd0), runs);
        if (runs) begin
            exp_out.push_back(ref_reg[r]);
        end
    endtask

    task automatic do_rtype(input func_t f, input logic [1:0] rs, input logic [1:0] rt,
                            input logic [1:0] rd);
        emit(r_word(f, rs, rt, rd), 1'b1);
        ref_reg[rd] = rtype_rule(f, ref_reg[rs], ref_reg[rt]);
    endtask

    task automatic do_imm(input opcode_t op, input logic [1:0] rs, input logic [1:0] rt,
                          input logic [7:0] imm);
        emit(i_word(op, rs, rt, imm), 1'b1);
        case (op)
            ADI_OP:  ref_reg[rt] = ref_reg[rs] + {{8{imm[7]}}, imm};
            ORI_OP:  ref_reg[rt] = ref_reg[rs] | {8'h00, imm};
            default: ref_reg[rt] = {imm, 8'h00};
        endcase
    endtask

    // Branch over a not-taken marker
    // r2 marks the not-taken path and r3 the taken path
    task automatic branch_case(input opcode_t op, input word_t x, input word_t y);
        bit taken;
        int here;
        load_reg(2'd0, x);
        load_reg(2'd1, y);
        case (op)
            BEQ_OP:  taken = (x == y);
            BNE_OP:  taken = (x != y);
            BGZ_OP:  taken = !x[15] && (x != 16'd0);
            default: taken = x[15];
        endcase
        emit(i_word(op, 2'd0, 2'd1, 8'd2), 1'b1);
        show_reg(2'd2, !taken);
        here = prog_word.size();
        emit(j_word(JMP_OP, 12'(here + 2)), !taken);
        show_reg(2'd3, taken);
    endtask

    task automatic build_program();
        word_t      v;
        logic [7:0] imm;
        int         here;
        lcg_state = 32'h11d99ba1;
        exec_count = 0;
        for (int r = 0; r < reg_count; r++) begin
            ref_reg[r] = '0;
        end
        // R-type functions on random operands
        for (int round = 0; round < 2; round++) begin
            load_reg(2'd0, next_rand());
            load_reg(2'd1, next_rand());
            for (int k = 0; k < 8; k++) begin
                do_rtype(func_t'(k[5:0]), 2'd0, 2'd1, 2'd2);
                show_reg(2'd2, 1'b1);
            end
        end
        // Immediate forms
        load_reg(2'd0, next_rand());
        v = next_rand();
        imm = v[7:0];
        do_imm(ADI_OP, 2'd0, 2'd3, imm | 8'h80);
        show_reg(2'd3, 1'b1);
        do_imm(ADI_OP, 2'd0, 2'd3, imm & 8'h7f);
        show_reg(2'd3, 1'b1);
        do_imm(ORI_OP, 2'd0, 2'd3, imm | 8'h80);
        show_reg(2'd3, 1'b1);
        do_imm(LHI_OP, 2'd0, 2'd3, v[15:8]);
        show_reg(2'd3, 1'b1);
        // Store then load back
        v = next_rand();
        store_addr = 32'h00c0 | int'(v[4:0]) + int'(v[10:8]);
        store_data = next_rand();
        load_reg(2'd1, word_t'(32'h00c0 | int'(v[4:0])));
        load_reg(2'd0, store_data);
        emit(i_word(SWD_OP, 2'd1, 2'd0, {5'd0, v[10:8]}), 1'b1);
        emit(i_word(LWD_OP, 2'd1, 2'd3, {5'd0, v[10:8]}), 1'b1);
        ref_reg[3] = store_data;
        show_reg(2'd3, 1'b1);
        // Branches, both outcomes of each
        load_reg(2'd2, 16'ha55a);
        load_reg(2'd3, 16'h3cc3);
        v = next_rand();
        branch_case(BEQ_OP, v, v);
        branch_case(BEQ_OP, v, v ^ 16'h0100);
        branch_case(BNE_OP, v, v ^ 16'h0001);
        branch_case(BNE_OP, v, v);
        branch_case(BGZ_OP, (next_rand() & 16'h7fff) | 16'h0001, v);
        branch_case(BGZ_OP, 16'h0000, v);
        branch_case(BLZ_OP, next_rand() | 16'h8000, v);
        branch_case(BLZ_OP, next_rand() & 16'h7fff, v);
        // JMP and JAL over a HLT
        here = prog_word.size();
        emit(j_word(JMP_OP, 12'(here + 2)), 1'b1);
        emit(r_word(FUNC_HLT, 2'd0, 2'd0, 2'd0), 1'b0);
        here = prog_word.size();
        emit(j_word(JAL_OP, 12'(here + 2)), 1'b1);
        emit(r_word(FUNC_HLT, 2'd0, 2'd0, 2'd0), 1'b0);
        ref_reg[2] = word_t'(here + 1);
        show_reg(2'd2, 1'b1);
        // JRL into a subroutine at here+5 and JPR back to here+3
        here = prog_word.size();
        load_reg(2'd1, word_t'(here + 5));
        emit(r_word(FUNC_JRL, 2'd1, 2'd0, 2'd0), 1'b1);
        emit(r_word(FUNC_WWD, 2'd2, 2'd0, 2'd0), 1'b1);
        emit(j_word(JMP_OP, 12'(here + 7)), 1'b1);
        emit(r_word(FUNC_WWD, 2'd1, 2'd0, 2'd0), 1'b1);
        emit(r_word(FUNC_JPR, 2'd2, 2'd0, 2'd0), 1'b1);
        exp_out.push_back(word_t'(here + 5));
        exp_out.push_back(word_t'(here + 3));
        emit(r_word(FUNC_HLT, 2'd0, 2'd0, 2'd0), 1'b1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic wait_output(input int n);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (output_valid !== 1'b1 && cycles < wait_limit);
        if (output_valid !== 1'b1) begin
            stop_with_failure($sformatf("Timeout: output_valid never arrived for WWD %0d", n));
        end
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (halted !== 1'b1 && cycles < wait_limit);
        if (halted !== 1'b1) begin
            stop_with_failure("Timeout: halted never arrived after the last WWD");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset_n = 1'b0;
        read_data <= '0;
        build_program();
        if (prog_word.size() > data_base) begin
            stop_with_failure("Program does not fit below the data area");
        end
        for (int a = 0; a < mem_words; a++) begin
            mem[a] = fill_word(a);
        end
        for (int a = 0; a < prog_word.size(); a++) begin
            mem[a] = prog_word[a];
        end
        repeat (3) @(negedge clk);
        reset_n = 1'b1;

        for (int n = 0; n < exp_out.size(); n++) begin
            wait_output(n);
            check_word("output_port", output_port, exp_out[n]);
            // The processor only halts after the last WWD
            check_flag("halted", halted, 1'b0);
        end
        wait_halt();
        check_word("num_inst", num_inst, word_t'(exec_count));
        check_word("mem_store_word", mem[store_addr], store_data);

        // Nothing more may come out after the halt
        repeat (quiet_cycles) begin
            @(negedge clk);
            if (output_valid !== 1'b0) begin
                stop_with_failure("output_valid pulsed after the processor halted");
            end
        end
        check_flag("halted", halted, 1'b1);
        check_word("num_inst", num_inst, word_t'(exec_count));
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* build.f */
common/tsc_isa_pkg.sv
common/cpu_ctrl_pkg.sv
datapath/alu.sv
datapath/register_file.sv
datapath/datapath.sv
control/control_unit.sv
hdl/cpu.sv
verif/cpu_assertions.sv
verif/cpu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cpu_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
